/* Makefile */
TOP := tb_cam_bist

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and pass only on the pass line"
	@echo "  clean  remove obj_dir"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f compile.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* cam_array.sv */
module cam_array #(
  parameter int RF_ENTRIES = 16,
  parameter int RF_DWIDTH  = 8,
  parameter int RF_AWIDTH  = 4
) (
  input  logic                  bist_clk,
  input  logic                  rst_n,
  input  logic                  fault_en,
  input  logic [RF_AWIDTH-1:0]  fault_addr,
  cam_bist_if.cam               ops,
  output logic [RF_ENTRIES-1:0] match_lines,
  output logic [RF_DWIDTH-1:0]  rd_data
);

  // Storage and its view with the defect applied
  logic [RF_DWIDTH-1:0]  mem     [RF_ENTRIES];
  logic [RF_DWIDTH-1:0]  eff_mem [RF_ENTRIES];
  // First pipeline stage
  logic [RF_ENTRIES-1:0] match_s1;
  logic [RF_DWIDTH-1:0]  rd_s1;

  // Stuck-at-1 on bit 0 of the faulted entry
  always_comb begin
    for (int i = 0; i < RF_ENTRIES; i++) begin
      eff_mem[i] = mem[i];
      if (fault_en && (fault_addr == RF_AWIDTH'(i))) begin
        eff_mem[i][0] = 1'b1;
      end
    end
  end

  // Write lands at the next edge
  always_ff @(posedge bist_clk) begin
    if (ops.wr_en) begin
      mem[ops.addr] <= ops.wdata;
    end
  end

  // ==================================================
  // Search and read pipeline
  // ==================================================
  always_ff @(posedge bist_clk) begin
    // Parallel compare of all entries against the key
    if (ops.srch_en) begin
      for (int i = 0; i < RF_ENTRIES; i++) begin
        match_s1[i] <= (eff_mem[i] == ops.wdata);
      end
    end
    if (ops.rd_en) begin
      rd_s1 <= eff_mem[ops.addr];
    end
    // Second stage
    match_lines <= match_s1;
    rd_data     <= rd_s1;
  end

  // Single-port array, no access may collide with a write
  a_no_wr_collision: assert property (@(posedge bist_clk) disable iff (!rst_n)
    ops.wr_en |-> !(ops.srch_en || ops.rd_en));

endmodule

/* cam_bist_checker.sv */
module cam_bist_checker
  import cam_bist_pkg::*;
#(
  parameter int RF_ENTRIES = 16,
  parameter int RF_DWIDTH  = 8,
  parameter int RF_AWIDTH  = 4
) (
  input  logic                 bist_clk,
  input  logic                 rst_n,
  input  logic                 bist_start,
  cam_bist_if.out              obs,
  input  logic [RF_DWIDTH-1:0] chk_data,
  output logic                 bist_fail,
  output bist_phase_t          fail_phase
);

  logic                 chk_en_d1, chk_en_d2;
  logic [RF_DWIDTH-1:0] exp_d1, exp_d2;
  bist_phase_t          phase_d1, phase_d2;
  logic                 mismatch;

  // Single-mismatch and zero-key searches need two entries and a two-bit word
  if (RF_ENTRIES < 2 || RF_DWIDTH < 2 || RF_AWIDTH < 1) begin : g_size_chk
    $error("cam_bist_checker: array too small for the CAM test algorithm");
  end

  // ==================================================
  // Expectation pipeline
  // ==================================================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      chk_en_d1 <= 1'b0;
      chk_en_d2 <= 1'b0;
      phase_d1  <= PH_IDLE;
      phase_d2  <= PH_IDLE;
    end else begin
      chk_en_d1 <= obs.chk_en;
      chk_en_d2 <= chk_en_d1;
      phase_d1  <= obs.phase;
      phase_d2  <= phase_d1;
    end
  end

  always_ff @(posedge bist_clk) begin
    exp_d1 <= obs.exp_data;
    exp_d2 <= exp_d1;
  end

  assign mismatch = chk_en_d2 && (chk_data != exp_d2);

  // Sticky fail, first failing phase only
  always_ff @(posedge bist_clk) begin
    if (!rst_n || bist_start) begin
      bist_fail  <= 1'b0;
      fail_phase <= PH_IDLE;
    end else if (mismatch && !bist_fail) begin
      bist_fail  <= 1'b1;
      fail_phase <= phase_d2;
    end
  end

  a_fail_sticky: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (bist_fail && !bist_start) |=> bist_fail);

endmodule

/* cam_bist_if.sv */
interface cam_bist_if
  import cam_bist_pkg::*;
#(
  parameter int RF_ENTRIES = 16,
  parameter int RF_DWIDTH  = 8,
  parameter int RF_AWIDTH  = 4
) ();

  // Operation strobes, one cycle each and mutually exclusive
  logic                 wr_en;
  logic                 srch_en;
  logic                 rd_en;
  logic [RF_AWIDTH-1:0] addr;
  // Write data or search key
  logic [RF_DWIDTH-1:0] wdata;
  // Compare context for the output side
  logic                 cm_mode;
  match_sel_t           match_sel;
  logic                 chk_en;
  logic [RF_DWIDTH-1:0] exp_data;
  bist_phase_t          phase;

  // Every entry must be reachable through addr
  if (RF_ENTRIES > (1 << RF_AWIDTH)) begin : g_size_chk
    $error("cam_bist_if: RF_ENTRIES does not fit in RF_AWIDTH address bits");
  end

  modport seq (output wr_en, srch_en, rd_en, addr, wdata, cm_mode,
               match_sel, chk_en, exp_data, phase);
  modport cam (input wr_en, srch_en, rd_en, addr, wdata);
  modport out (input addr, cm_mode, match_sel, chk_en, exp_data, phase);

endinterface

/* cam_bist_outhandler.sv */
module cam_bist_outhandler
  import cam_bist_pkg::*;
#(
  parameter int RF_ENTRIES = 16,
  parameter int RF_DWIDTH  = 8,
  parameter int RF_AWIDTH  = 4
) (
  input  logic                  bist_clk,
  cam_bist_if.out               obs,
  input  logic [RF_ENTRIES-1:0] match_lines,
  input  logic [RF_DWIDTH-1:0]  rd_data,
  output logic [RF_DWIDTH-1:0]  chk_data
);

  // Compare context aligned with array results
  logic [RF_AWIDTH-1:0]  addr_d1, addr_d2;
  logic                  cm_mode_d1, cm_mode_d2;
  match_sel_t            sel_d1, sel_d2;
  logic [RF_ENTRIES-1:0] one_hot;
  logic [RF_ENTRIES-1:0] exp_match;
  logic [RF_ENTRIES-1:0] match_diff;
  logic [RF_DWIDTH-1:0]  cmp_data;

  always_ff @(posedge bist_clk) begin
    addr_d1    <= obs.addr;
    addr_d2    <= addr_d1;
    cm_mode_d1 <= obs.cm_mode;
    cm_mode_d2 <= cm_mode_d1;
    sel_d1     <= obs.match_sel;
    sel_d2     <= sel_d1;
  end

  // ==================================================
  // Expected match vector and compare
  // ==================================================
  assign one_hot = RF_ENTRIES'(1) << addr_d2;

  always_comb begin
    case (sel_d2)
      MS_ALL_MATCH:       exp_match = '1;
      MS_SINGLE_MATCH:    exp_match = one_hot;
      MS_SINGLE_MISMATCH: exp_match = ~one_hot;
      default:            exp_match = '0;
    endcase
  end

  // Any set bit is a wrong match line
  assign match_diff = exp_match ^ match_lines;

  // ==================================================
  // Compaction onto the data width
  // ==================================================
  if (RF_DWIDTH < RF_ENTRIES) begin : g_fold
    // Entry i folds into bit i mod width
    always_comb begin
      cmp_data = '0;
      for (int i = 0; i < RF_ENTRIES; i++) begin
        cmp_data[i % RF_DWIDTH] = cmp_data[i % RF_DWIDTH] | match_diff[i];
      end
    end
  end else if (RF_DWIDTH == RF_ENTRIES) begin : g_equal
    assign cmp_data = match_diff;
  end else begin : g_pad
    assign cmp_data = {{(RF_DWIDTH - RF_ENTRIES){1'b0}}, match_diff};
  end

  // Compare result in search mode, read data otherwise
  assign chk_data = cm_mode_d2 ? cmp_data : rd_data;

endmodule

/* cam_bist_pkg.sv */
package cam_bist_pkg;

  // Widest data word the background function can produce
  localparam int MAX_DWIDTH = 64;

  // ==================================================
  // Algorithm phases
  // ==================================================

  // One value per step of the CAM test, in execution order
  typedef enum logic [3:0] {
    PH_IDLE          = 4'd0,
    PH_FILL          = 4'd1,
    PH_SEARCH_ALL    = 4'd2,
    PH_MARCH_WRITE   = 4'd3,
    PH_MARCH_HIT     = 4'd4,
    PH_MARCH_MISS    = 4'd5,
    PH_MARCH_RESTORE = 4'd6,
    PH_SEARCH_NONE   = 4'd7,
    PH_READ          = 4'd8,
    PH_DRAIN         = 4'd9,
    PH_DONE          = 4'd10
  } bist_phase_t;

  // Expected match pattern, {sel1, sel0} encoding
  typedef enum logic [1:0] {
    MS_ALL_MATCH       = 2'b00,
    MS_SINGLE_MATCH    = 2'b01,
    MS_SINGLE_MISMATCH = 2'b10,
    MS_ALL_MISMATCH    = 2'b11
  } match_sel_t;

  // Alternating 1010 pattern with bit 0 low, upper bits beyond width are zero
  function automatic logic [MAX_DWIDTH-1:0] background_word(input int width);
    logic [MAX_DWIDTH-1:0] word;
    word = '0;
    for (int i = 0; i < width && i < MAX_DWIDTH; i++) begin
      word[i] = (i % 2) == 1;
    end
    return word;
  endfunction

endpackage

/* cam_bist_sequencer.sv */
module cam_bist_sequencer
  import cam_bist_pkg::*;
#(
  parameter int RF_ENTRIES = 16,
  parameter int RF_DWIDTH  = 8,
  parameter int RF_AWIDTH  = 4
) (
  input  logic  bist_clk,
  input  logic  rst_n,
  input  logic  bist_start,
  output logic  bist_done,
  cam_bist_if.seq ctl
);

  localparam logic [MAX_DWIDTH-1:0] BG_FULL   = background_word(RF_DWIDTH);
  localparam logic [RF_DWIDTH-1:0]  BG        = BG_FULL[RF_DWIDTH-1:0];
  localparam logic [RF_AWIDTH-1:0]  LAST_ADDR = RF_AWIDTH'(RF_ENTRIES - 1);

  bist_phase_t          phase;
  logic [RF_AWIDTH-1:0] addr_cnt;
  logic                 last_entry;

  assign last_entry = (addr_cnt == LAST_ADDR);
  assign bist_done  = (phase == PH_DONE);

  // ==================================================
  // Phase and address stepping
  // ==================================================
  always_ff @(posedge bist_clk) begin
    if (!rst_n) begin
      phase    <= PH_IDLE;
      addr_cnt <= '0;
    end else begin
      case (phase)
        PH_IDLE, PH_DONE: begin
          if (bist_start) begin
            phase    <= PH_FILL;
            addr_cnt <= '0;
          end
        end
        PH_FILL: begin
          if (last_entry) begin
            phase    <= PH_SEARCH_ALL;
            addr_cnt <= '0;
          end else begin
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
        PH_SEARCH_ALL:  phase <= PH_MARCH_WRITE;
        PH_MARCH_WRITE: phase <= PH_MARCH_HIT;
        PH_MARCH_HIT:   phase <= PH_MARCH_MISS;
        PH_MARCH_MISS:  phase <= PH_MARCH_RESTORE;
        PH_MARCH_RESTORE: begin
          // Four operations per entry, then on to the next one
          if (last_entry) begin
            phase    <= PH_SEARCH_NONE;
            addr_cnt <= '0;
          end else begin
            phase    <= PH_MARCH_WRITE;
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
        PH_SEARCH_NONE: phase <= PH_READ;
        PH_READ: begin
          if (last_entry) begin
            phase    <= PH_DRAIN;
            addr_cnt <= '0;
          end else begin
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
        PH_DRAIN: begin
          // Two idle cycles let the last read clear the pipeline
          if (addr_cnt == RF_AWIDTH'(1)) begin
            phase    <= PH_DONE;
            addr_cnt <= '0;
          end else begin
            addr_cnt <= addr_cnt + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // ==================================================
  // Operation decode
  // ==================================================
  always_comb begin
    ctl.wr_en     = 1'b0;
    ctl.srch_en   = 1'b0;
    ctl.rd_en     = 1'b0;
    ctl.addr      = addr_cnt;
    ctl.wdata     = BG;
    ctl.cm_mode   = 1'b0;
    ctl.match_sel = MS_ALL_MATCH;
    ctl.chk_en    = 1'b0;
    ctl.exp_data  = '0;
    ctl.phase     = phase;
    case (phase)
      PH_FILL, PH_MARCH_RESTORE: ctl.wr_en = 1'b1;
      PH_MARCH_WRITE: begin
        ctl.wr_en = 1'b1;
        ctl.wdata = ~BG;
      end
      PH_SEARCH_ALL, PH_MARCH_HIT, PH_MARCH_MISS, PH_SEARCH_NONE: begin
        ctl.srch_en = 1'b1;
        ctl.cm_mode = 1'b1;
        ctl.chk_en  = 1'b1;
        // Only the addressed entry holds the inverted word
        if (phase == PH_MARCH_HIT) begin
          ctl.wdata     = ~BG;
          ctl.match_sel = MS_SINGLE_MATCH;
        end else if (phase == PH_MARCH_MISS) begin
          ctl.match_sel = MS_SINGLE_MISMATCH;
        end else if (phase == PH_SEARCH_NONE) begin
          ctl.wdata     = '0;
          ctl.match_sel = MS_ALL_MISMATCH;
        end
      end
      PH_READ: begin
        ctl.rd_en    = 1'b1;
        ctl.chk_en   = 1'b1;
        ctl.exp_data = BG;
      end
      default: ;
    endcase
  end

  // Strobes never overlap
  a_one_op: assert property (@(posedge bist_clk) disable iff (!rst_n)
    $onehot0({ctl.wr_en, ctl.srch_en, ctl.rd_en}));

endmodule

/* cam_bist_top.sv */
module cam_bist_top
  import cam_bist_pkg::*;
#(
  parameter int RF_ENTRIES = 16,
  parameter int RF_DWIDTH  = 8,
  parameter int RF_AWIDTH  = 4
) (
  input  logic                 bist_clk,
  input  logic                 rst_n,
  input  logic                 bist_start,
  input  logic                 fault_en,
  input  logic [RF_AWIDTH-1:0] fault_addr,
  output logic                 bist_done,
  output logic                 bist_fail,
  output bist_phase_t          fail_phase
);

  // Array results and handler output
  logic [RF_ENTRIES-1:0] match_lines;
  logic [RF_DWIDTH-1:0]  rd_data;
  logic [RF_DWIDTH-1:0]  chk_data;

  // Test operation bus
  cam_bist_if #(
    .RF_ENTRIES(RF_ENTRIES), .RF_DWIDTH(RF_DWIDTH), .RF_AWIDTH(RF_AWIDTH)
  ) bist_bus ();

  cam_bist_sequencer #(
    .RF_ENTRIES(RF_ENTRIES), .RF_DWIDTH(RF_DWIDTH), .RF_AWIDTH(RF_AWIDTH)
  ) u_sequencer (
    .bist_clk(bist_clk), .rst_n(rst_n), .bist_start(bist_start),
    .bist_done(bist_done), .ctl(bist_bus.seq)
  );

  cam_array #(
    .RF_ENTRIES(RF_ENTRIES), .RF_DWIDTH(RF_DWIDTH), .RF_AWIDTH(RF_AWIDTH)
  ) u_array (
    .bist_clk(bist_clk), .rst_n(rst_n), .fault_en(fault_en), .fault_addr(fault_addr),
    .ops(bist_bus.cam), .match_lines(match_lines), .rd_data(rd_data)
  );

  cam_bist_outhandler #(
    .RF_ENTRIES(RF_ENTRIES), .RF_DWIDTH(RF_DWIDTH), .RF_AWIDTH(RF_AWIDTH)
  ) u_outhandler (
    .bist_clk(bist_clk), .obs(bist_bus.out), .match_lines(match_lines),
    .rd_data(rd_data), .chk_data(chk_data)
  );

  cam_bist_checker #(
    .RF_ENTRIES(RF_ENTRIES), .RF_DWIDTH(RF_DWIDTH), .RF_AWIDTH(RF_AWIDTH)
  ) u_checker (
    .bist_clk(bist_clk), .rst_n(rst_n), .bist_start(bist_start), .obs(bist_bus.out),
    .chk_data(chk_data), .bist_fail(bist_fail), .fail_phase(fail_phase)
  );

endmodule

/* compile.f */
cam_bist_pkg.sv
cam_bist_if.sv
cam_bist_sequencer.sv
cam_array.sv
cam_bist_outhandler.sv
cam_bist_checker.sv
cam_bist_top.sv
tb_cam_bist.sv

/* tb_cam_bist.sv */
module tb_cam_bist
  import cam_bist_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int RF_ENTRIES = 16;
  localparam int RF_DWIDTH  = 8;
  localparam int RF_AWIDTH  = 4;
  // Fill, all-match, march, all-mismatch, read, drain
  localparam int RUN_CYC      = 6 * RF_ENTRIES + 4;
  localparam int WATCHDOG_CYC = 4 * (6 * RF_ENTRIES + 20);

  logic                 bist_clk = 1'b0;
  logic                 rst_n;
  logic                 bist_start;
  logic                 fault_en;
  logic [RF_AWIDTH-1:0] fault_addr;
  logic                 bist_done;
  logic                 bist_fail;
  bist_phase_t          fail_phase;

  int   errors  = 0;
  int   seed    = 32'h7e1b1026;
  // Edges seen since the start was sampled, zero when no run is timed
  int   cyc     = 0;
  logic started = 1'b0;

  cam_bist_top #(
    .RF_ENTRIES(RF_ENTRIES), .RF_DWIDTH(RF_DWIDTH), .RF_AWIDTH(RF_AWIDTH)
  ) DUT (
    .bist_clk(bist_clk), .rst_n(rst_n), .bist_start(bist_start), .fault_en(fault_en),
    .fault_addr(fault_addr), .bist_done(bist_done), .bist_fail(bist_fail),
    .fail_phase(fail_phase)
  );

  // 40 ns period
  always #20 bist_clk = ~bist_clk;

  // Run timer
  always @(posedge bist_clk) begin
    if (!rst_n) begin
      cyc <= 0;
    end else if (bist_start) begin
      cyc <= 1;
      started <= 1'b1;
    end else if (cyc == RUN_CYC + 1) begin
      cyc <= 0;
    end else if (cyc != 0) begin
      cyc <= cyc + 1;
    end
  end

  task automatic value_error(input string sig, input logic [31:0] got, input logic [31:0] exp);
    errors++;
    $display("Error: %s = 0x%0h, expected 0x%0h at %0t ns", sig, got, exp, $time);
  endtask

  task automatic event_error(input string what);
    errors++;
    $display("Check failed at %0t ns: %s", $time, what);
  endtask

  // ==================================================
  // Checks
  // ==================================================
  // Quiet outputs until the first start
  a_idle_done: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !started |-> !bist_done)
    else value_error("bist_done", 32'($sampled(bist_done)), 32'h0);
  a_idle_fail: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !started |-> !bist_fail)
    else value_error("bist_fail", 32'($sampled(bist_fail)), 32'h0);
  a_idle_phase: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !started |-> fail_phase == PH_IDLE)
    else value_error("fail_phase", 32'($sampled(fail_phase)), 32'(PH_IDLE));

  // Done rises exactly RUN_CYC edges after start, not earlier
  a_done_early: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (cyc != 0 && cyc <= RUN_CYC) |-> !bist_done)
    else event_error("bist_done rose before the end of the test algorithm");
  a_done_time: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (cyc == RUN_CYC + 1) |-> bist_done)
    else value_error("bist_done", 32'($sampled(bist_done)), 32'h1);
  a_done_hold: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (bist_done && !bist_start) |=> bist_done)
    else event_error("bist_done dropped without a new start");

  // Fault-free runs
  a_clean_no_rise: assert property (@(posedge bist_clk) disable iff (!rst_n)
    !fault_en |-> !$rose(bist_fail))
    else event_error("bist_fail rose while no fault was injected");
  a_clean_fail: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (bist_done && !fault_en && !bist_start) |-> !bist_fail)
    else value_error("bist_fail", 32'($sampled(bist_fail)), 32'h0);
  a_clean_phase: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (bist_done && !fault_en && !bist_start) |-> fail_phase == PH_IDLE)
    else value_error("fail_phase", 32'($sampled(fail_phase)), 32'(PH_IDLE));

  // Stuck bit 0 breaks the all-match search first
  a_fault_fail: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (bist_done && fault_en && !bist_start) |-> bist_fail)
    else value_error("bist_fail", 32'($sampled(bist_fail)), 32'h1);
  a_fault_phase: assert property (@(posedge bist_clk) disable iff (!rst_n)
    (bist_done && fault_en && !bist_start) |-> fail_phase == PH_SEARCH_ALL)
    else value_error("fail_phase", 32'($sampled(fail_phase)), 32'(PH_SEARCH_ALL));

  // New start clears the result
  a_start_fail: assert property (@(posedge bist_clk) disable iff (!rst_n)
    bist_start |=> !bist_fail)
    else value_error("bist_fail", 32'($sampled(bist_fail)), 32'h0);
  a_start_phase: assert property (@(posedge bist_clk) disable iff (!rst_n)
    bist_start |=> fail_phase == PH_IDLE)
    else value_error("fail_phase", 32'($sampled(fail_phase)), 32'(PH_IDLE));

  // ==================================================
  // Stimulus
  // ==================================================
  task automatic run_bist(input logic with_fault);
    int unsigned pick;
    pick = $unsigned($random(seed));
    @(posedge bist_clk);
    #2;
    bist_start = 1'b1;
    fault_en   = with_fault;
    fault_addr = with_fault ? RF_AWIDTH'(pick % RF_ENTRIES) : '0;
    @(posedge bist_clk);
    #2;
    bist_start = 1'b0;
    // Wait for the sequencer to reach done
    while (!bist_done) begin
      @(posedge bist_clk);
      #2;
    end
    $display("Run finished, fault %0b at entry %0d, fail %0b", with_fault, fault_addr,
             bist_fail);
    repeat (3) @(posedge bist_clk);
  endtask

  initial begin
    rst_n      = 1'b0;
    bist_start = 1'b0;
    fault_en   = 1'b0;
    fault_addr = '0;
    repeat (4) @(posedge bist_clk);
    #2;
    rst_n = 1'b1;
    // Idle cycles before the first start
    repeat (3) @(posedge bist_clk);
    run_bist(1'b0);
    run_bist(1'b1);
    run_bist(1'b1);
    run_bist(1'b0);
    repeat (3) @(posedge bist_clk);
    $display("Checks complete, %0d errors", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

  // Watchdog
  initial begin
    repeat (WATCHDOG_CYC) @(posedge bist_clk);
    errors++;
    $display("Timeout: the four BIST runs did not finish within %0d cycles", WATCHDOG_CYC);
    $display("Checks complete, %0d errors", errors);
    $display("Errors found");
    $finish;
  end

endmodule
